// File: verilog.f
+incdir+common
common/mips_pkg.sv
src/mips_alu.sv
src/regfile.sv
src/mem_align.sv
src/pc_unit.sv
decode/mips_decode.sv
src/mips_core.sv
test/mips_asserts.sv
test/tb_mips_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mips_core
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Checks failed
PASS_MSG  = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation stopped early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_mips_core.sv
// mips core testbench
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_core;
   import mips_pkg::*;

   // five tests at up to 200 cycles each
   localparam int CYCLE_LIMIT = 5 * 200;
   localparam int RUN_LIMIT   = 200;

   logic       clk;
   logic       rst_b;
   logic       ram_clear;
   word_addr_t inst_addr;
   word_t      inst;
   word_addr_t mem_addr;
   word_t      mem_data_in;
   word_t      mem_data_out;
   byte_en_t   mem_write_en;
   logic       halted;

   // instruction rom from the text base, data ram from address 0
   word_t  rom [256];
   word_t  ram [256];
   int     prog_len;
   int     cycles = 0;
   int     errors;
   int     checks;
   integer seed;

   mips_core mips_core_inst (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .mem_addr(mem_addr), .mem_data_in(mem_data_in), .mem_data_out(mem_data_out),
      .mem_write_en(mem_write_en), .halted(halted)
   );

   bind mips_core mips_asserts mips_asserts_inst (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr),
      .mem_write_en(mem_write_en), .halted(halted)
   );

   // both memories answer within the cycle
   assign inst         = rom[inst_addr[7:0]];
   assign mem_data_out = ram[mem_addr[7:0]];

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // lanes c0, de, 00 and the index, so loads see both signs
   function automatic word_t fill_word(int idx);
      return {16'hc0de, 8'h00, idx[7:0]};
   endfunction

   // ram refills during reset, otherwise byte lanes follow the mask
   always @(posedge clk)
   begin
      if (ram_clear)
      begin
         for (int i = 0; i < 256; i++)
         begin
            ram[i] <= fill_word(i);
         end
      end
      else
      begin
         for (int b = 0; b < 4; b++)
         begin
            if (mem_write_en[b])
            begin
               ram[mem_addr[7:0]][8*b +: 8] <= mem_data_in[8*b +: 8];
            end
         end
      end
   end

   // watchdog over the whole run
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   function automatic word_t rtype_word(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt,
                                        reg_idx_t rd, logic [4:0] sh);
      return {`MIPS_OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t itype_word(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                        logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // jump to a rom slot inside the text segment
   function automatic word_t jtype_word(logic [5:0] op, int idx);
      word_t addr;
      addr = `MIPS_TEXT_START + 4 * idx;
      return {op, addr[27:2]};
   endfunction

   function automatic word_t syscall_word();
      return rtype_word(`MIPS_FN_SYSCALL, 0, 0, 0, 0);
   endfunction

   // unloaded slots hold unknown opcodes, so a stray fetch halts
   task automatic clear_rom();
      for (int i = 0; i < 256; i++)
      begin
         rom[i] = {6'h3f, 18'h0, i[7:0]};
      end
      prog_len = 0;
   endtask

   task automatic emit(word_t w);
      rom[prog_len] = w;
      prog_len++;
   endtask

   task automatic load_const(reg_idx_t r, word_t v);
      emit(itype_word(`MIPS_OP_LUI, 0, r, v[31:16]));
      emit(itype_word(`MIPS_OP_ORI, r, r, v[15:0]));
   endtask

   task automatic store_word(reg_idx_t r, int offset);
      emit(itype_word(`MIPS_OP_SW, 0, r, offset[15:0]));
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst_b     <= 1'b0;
      ram_clear <= 1'b1;
      repeat (2) @(posedge clk);
      rst_b     <= 1'b1;
      ram_clear <= 1'b0;
   endtask

   task automatic check_word(string what, word_t got, word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t %s: got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_mask(string what, byte_en_t got, byte_en_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t %s: got %b expected %b", $time, what, got, exp);
      end
   endtask

   // mid-cycle sampling, optionally checks the mask at one rom slot
   task automatic run_until_halted(int watch_idx, byte_en_t watch_mask);
      logic done;
      done = 1'b0;
      for (int n = 0; n < RUN_LIMIT && !done; n++)
      begin
         @(negedge clk);
         if (halted)
         begin
            done = 1'b1;
         end
         else if (watch_idx >= 0 && inst_addr[7:0] == watch_idx[7:0])
         begin
            check_mask("mem_write_en", mem_write_en, watch_mask);
         end
      end
      if (!done)
      begin
         errors++;
         $display("core did not halt within %0d cycles", RUN_LIMIT);
      end
   endtask

   task automatic alu_ops();
      word_t      a;
      word_t      b;
      logic [4:0] sh;
      logic [15:0] k;
      word_t      ops [16];
      word_t      exp [16];
      // negative a exercises the sra fill and the signed compare
      a  = $random(seed) | 32'h8000_0000;
      b  = $random(seed);
      sh = 5'($random(seed));
      k  = 16'($random(seed));
      ops[0]  = rtype_word(`MIPS_FN_ADDU, 8, 9, 10, 0);
      exp[0]  = a + b;
      ops[1]  = rtype_word(`MIPS_FN_SUBU, 8, 9, 10, 0);
      exp[1]  = a - b;
      ops[2]  = rtype_word(`MIPS_FN_AND, 8, 9, 10, 0);
      exp[2]  = a & b;
      ops[3]  = rtype_word(`MIPS_FN_OR, 8, 9, 10, 0);
      exp[3]  = a | b;
      ops[4]  = rtype_word(`MIPS_FN_XOR, 8, 9, 10, 0);
      exp[4]  = a ^ b;
      ops[5]  = rtype_word(`MIPS_FN_NOR, 8, 9, 10, 0);
      exp[5]  = ~(a | b);
      ops[6]  = rtype_word(`MIPS_FN_SLT, 8, 9, 10, 0);
      exp[6]  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ops[7]  = rtype_word(`MIPS_FN_SLT, 9, 8, 10, 0);
      exp[7]  = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
      // shifts read rt
      ops[8]  = rtype_word(`MIPS_FN_SLL, 0, 8, 10, sh);
      exp[8]  = a << sh;
      ops[9]  = rtype_word(`MIPS_FN_SRL, 0, 8, 10, sh);
      exp[9]  = a >> sh;
      ops[10] = rtype_word(`MIPS_FN_SRA, 0, 8, 10, sh);
      exp[10] = word_t'($signed(a) >>> sh);
      ops[11] = itype_word(`MIPS_OP_ADDIU, 8, 10, k);
      exp[11] = a + {{16{k[15]}}, k};
      ops[12] = itype_word(`MIPS_OP_ANDI, 8, 10, k);
      exp[12] = a & {16'h0000, k};
      ops[13] = itype_word(`MIPS_OP_ORI, 8, 10, k);
      exp[13] = a | {16'h0000, k};
      ops[14] = itype_word(`MIPS_OP_XORI, 8, 10, k);
      exp[14] = a ^ {16'h0000, k};
      ops[15] = itype_word(`MIPS_OP_LUI, 0, 10, k);
      exp[15] = {k, 16'h0000};
      clear_rom();
      load_const(8, a);
      load_const(9, b);
      for (int s = 0; s < 16; s++)
      begin
         emit(ops[s]);
         store_word(10, 'h100 + 4 * s);
      end
      emit(syscall_word());
      apply_reset();
      run_until_halted(-1, '0);
      for (int s = 0; s < 16; s++)
      begin
         check_word($sformatf("alu result %0d", s), ram[64 + s], exp[s]);
      end
   endtask

   task automatic load_store_lanes();
      logic [7:0] v;
      logic [7:0] lane;
      word_t      exp_word;
      for (int k = 0; k < 4; k++)
      begin
         v = 8'($random(seed));
         clear_rom();
         emit(itype_word(`MIPS_OP_ORI, 0, 9, {8'h00, v}));
         // sb sits at rom slot 1
         emit(itype_word(`MIPS_OP_SB, 0, 9, 16'('h200 + k)));
         emit(itype_word(`MIPS_OP_LB, 0, 10, 16'('h204 + k)));
         store_word(10, 'h300);
         emit(itype_word(`MIPS_OP_LBU, 0, 11, 16'('h204 + k)));
         store_word(11, 'h304);
         emit(syscall_word());
         apply_reset();
         // lane k owns mask bit 3-k
         run_until_halted(1, byte_en_t'(1) << (3 - k));
         // big-endian, offset k is bits 31-8k down to 24-8k
         exp_word = fill_word(128);
         exp_word[31 - 8*k -: 8] = v;
         check_word($sformatf("sb word, offset %0d", k), ram[128], exp_word);
         check_word($sformatf("neighbour word, offset %0d", k), ram[129], fill_word(129));
         lane = 8'(fill_word(129) >> (24 - 8*k));
         check_word($sformatf("lb, offset %0d", k), ram[192], {{24{lane[7]}}, lane});
         check_word($sformatf("lbu, offset %0d", k), ram[193], {24'h000000, lane});
      end
   endtask

   task automatic branch_delay_slots();
      word_t marks [10];
      marks = '{32'h11, 32'h0, 32'h33, 32'h44, 32'h55, 32'h0, 32'h77, 32'h88, 32'h99, 32'haa};
      clear_rom();
      emit(itype_word(`MIPS_OP_ORI, 0, 8, 16'd5));
      emit(itype_word(`MIPS_OP_ORI, 0, 9, 16'd5));
      emit(itype_word(`MIPS_OP_ORI, 0, 10, 16'd7));
      // taken beq, slot 5 is skipped
      emit(itype_word(`MIPS_OP_BEQ, 8, 9, 16'd2));
      emit(itype_word(`MIPS_OP_ORI, 0, 11, 16'h11));
      emit(itype_word(`MIPS_OP_ORI, 0, 12, 16'h22));
      // untaken bne falls through
      emit(itype_word(`MIPS_OP_BNE, 8, 9, 16'd2));
      emit(itype_word(`MIPS_OP_ORI, 0, 13, 16'h33));
      emit(itype_word(`MIPS_OP_ORI, 0, 14, 16'h44));
      // taken bne, slot 11 is skipped
      emit(itype_word(`MIPS_OP_BNE, 8, 10, 16'd2));
      emit(itype_word(`MIPS_OP_ORI, 0, 15, 16'h55));
      emit(itype_word(`MIPS_OP_ORI, 0, 16, 16'h66));
      // untaken beq
      emit(itype_word(`MIPS_OP_BEQ, 8, 10, 16'd2));
      emit(itype_word(`MIPS_OP_ORI, 0, 17, 16'h77));
      emit(itype_word(`MIPS_OP_ORI, 0, 18, 16'h88));
      // call at slot 15, returns to slot 17
      emit(jtype_word(`MIPS_OP_JAL, 40));
      emit(itype_word(`MIPS_OP_ORI, 0, 19, 16'h99));
      for (int r = 11; r <= 20; r++)
      begin
         store_word(r, 'h100 + 4 * (r - 11));
      end
      emit(syscall_word());
      // subroutine
      prog_len = 40;
      store_word(31, 'h180);
      emit(rtype_word(`MIPS_FN_JR, 31, 0, 0, 0));
      emit(itype_word(`MIPS_OP_ORI, 0, 20, 16'haa));
      apply_reset();
      run_until_halted(-1, '0);
      for (int r = 11; r <= 20; r++)
      begin
         check_word($sformatf("marker r%0d", r), ram[64 + r - 11], marks[r - 11]);
      end
      check_word("jal link", ram[96], `MIPS_TEXT_START + 15 * 4 + 8);
   endtask

   task automatic syscall_halt();
      word_t      v;
      word_addr_t frozen;
      v = {16'h0000, 16'($random(seed))};
      clear_rom();
      emit(itype_word(`MIPS_OP_ORI, 0, 8, v[15:0]));
      store_word(8, 'h100);
      emit(syscall_word());
      store_word(8, 'h104);
      store_word(8, 'h108);
      apply_reset();
      run_until_halted(-1, '0);
      frozen = inst_addr;
      check_word("inst_addr at halt", {2'b00, frozen}, (`MIPS_TEXT_START >> 2) + 2);
      // a store fetched under the frozen pc must stay blocked
      @(posedge clk);
      rom[frozen[7:0]] <= itype_word(`MIPS_OP_SW, 0, 8, 16'h0104);
      repeat (4)
      begin
         @(negedge clk);
         check_word("inst_addr while halted", {2'b00, inst_addr}, {2'b00, frozen});
         check_mask("mem_write_en while halted", mem_write_en, '0);
         if (!halted)
         begin
            errors++;
            $display("halted dropped without a reset");
         end
      end
      check_word("store before syscall", ram[64], v);
      check_word("store after syscall", ram[65], fill_word(65));
      check_word("second store after syscall", ram[66], fill_word(66));
   endtask

   task automatic unknown_op_reset();
      word_t v;
      // nonzero, so a zero read after reset means a cleared register
      v = {16'h0000, 16'($random(seed))} | 32'h1;
      clear_rom();
      emit(itype_word(`MIPS_OP_ORI, 0, 5, v[15:0]));
      store_word(5, 'h100);
      emit(32'hfc00_0000);
      store_word(5, 'h104);
      apply_reset();
      run_until_halted(-1, '0);
      check_word("store before unknown opcode", ram[64], v);
      check_word("store after unknown opcode", ram[65], fill_word(65));
      // core is stopped, so the next program goes in underneath it
      clear_rom();
      store_word(5, 'h108);
      emit(syscall_word());
      apply_reset();
      @(negedge clk);
      check_word("inst_addr after reset", {2'b00, inst_addr}, `MIPS_TEXT_START >> 2);
      if (halted)
      begin
         errors++;
         $display("halted still high after reset");
      end
      run_until_halted(-1, '0);
      check_word("r5 after reset", ram[66], 32'h0);
   endtask

   initial
   begin
      rst_b     = 1'b0;
      ram_clear = 1'b0;
      seed      = 32'he646_2038;
      errors    = 0;
      checks    = 0;
      alu_ops();
      load_store_lanes();
      branch_delay_slots();
      syscall_halt();
      unknown_op_reset();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: test/mips_asserts.sv
// mips core output properties
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_asserts (
   input logic                 clk,
   input logic                 rst_b,
   input mips_pkg::word_addr_t inst_addr,
   input mips_pkg::byte_en_t   mem_write_en,
   input logic                 halted
);
   import mips_pkg::*;

   // a stopped core leaves memory alone
   no_write_when_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> mem_write_en == '0)
      else $error("memory write enable set while halted");

   // only reset clears the halt flag
   halt_is_sticky: assert property (@(posedge clk)
      $fell(halted) |-> !rst_b)
      else $error("halted fell without reset");

   // fetch address frozen once halted
   fetch_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      $past(halted) && halted |-> $stable(inst_addr))
      else $error("inst_addr moved while halted");

   // first fetch after reset comes from the text base
   fetch_after_reset: assert property (@(posedge clk)
      $rose(rst_b) |-> inst_addr == word_addr_t'(`MIPS_TEXT_START >> 2))
      else $error("inst_addr wrong after reset");

endmodule

// File: src/mips_core.sv
// mips single-cycle core
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_pkg::word_addr_t inst_addr,
   input  mips_pkg::word_t      inst,
   output mips_pkg::word_addr_t mem_addr,
   output mips_pkg::word_t      mem_data_in,
   input  mips_pkg::word_t      mem_data_out,
   output mips_pkg::byte_en_t   mem_write_en,
   output logic                 halted
);
   import mips_pkg::*;

   alu_op_e  alu_op;
   mem_op_e  mem_op;
   pc_sel_e  pc_sel;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t dest;
   reg_idx_t wr_idx;
   word_t    imm;
   word_t    pc;
   word_t    link_addr;
   word_t    rs_data;
   word_t    rt_data;
   word_t    op_a;
   word_t    op_b;
   word_t    alu_result;
   word_t    load_data;
   word_t    wr_data;
   logic     use_imm;
   logic     use_shamt;
   logic     reg_write;
   logic     link;
   logic     is_bne;
   logic     halt_req;
   logic     alu_zero;
   logic     is_load;
   logic     wr_en;

   // fetch and data addresses are word aligned
   assign inst_addr = pc[31:2];
   assign mem_addr  = alu_result[31:2];

   mips_decode decode_inst (
      .inst(inst), .alu_op(alu_op), .mem_op(mem_op), .pc_sel(pc_sel),
      .rs(rs), .rt(rt), .dest(dest), .imm(imm),
      .use_imm(use_imm), .use_shamt(use_shamt), .reg_write(reg_write),
      .link(link), .is_bne(is_bne), .halt_req(halt_req)
   );

   pc_unit pc_unit_inst (
      .clk(clk), .rst_b(rst_b), .pc_sel(pc_sel), .is_bne(is_bne),
      .alu_zero(alu_zero), .imm(imm), .jump_index(inst[25:0]),
      .rs_data(rs_data), .halt_req(halt_req),
      .pc(pc), .link_addr(link_addr), .halted(halted)
   );

   // jal overrides the decoded destination
   assign wr_idx = link ? `MIPS_LINK_REG : dest;
   // nothing retires once the core has stopped
   assign wr_en  = reg_write & ~halted;

   regfile regfile_inst (
      .clk(clk), .rst_b(rst_b), .rs(rs), .rt(rt), .wr_idx(wr_idx),
      .wr_data(wr_data), .wr_en(wr_en), .rs_data(rs_data), .rt_data(rt_data)
   );

   // shifts act on rt, everything else on rs
   assign op_a = use_shamt ? rt_data : rs_data;
   assign op_b = use_imm ? imm : rt_data;

   mips_alu alu_inst (
      .op_a(op_a), .op_b(op_b), .shamt(inst[10:6]), .alu_op(alu_op),
      .result(alu_result), .zero(alu_zero)
   );

   mem_align mem_align_inst (
      .mem_op(mem_op), .byte_sel(alu_result[1:0]), .rt_data(rt_data),
      .mem_data_out(mem_data_out), .halted(halted),
      .mem_write_en(mem_write_en), .mem_data_in(mem_data_in), .load_data(load_data)
   );

   // writeback source: link address, load value or alu result
   assign is_load = (mem_op == MEM_LW) || (mem_op == MEM_LB) || (mem_op == MEM_LBU);
   assign wr_data = link ? link_addr : (is_load ? load_data : alu_result);

endmodule

// File: decode/mips_decode.sv
// instruction decoder
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_decode (
   input  mips_pkg::word_t    inst,
   output mips_pkg::alu_op_e  alu_op,
   output mips_pkg::mem_op_e  mem_op,
   output mips_pkg::pc_sel_e  pc_sel,
   output mips_pkg::reg_idx_t rs,
   output mips_pkg::reg_idx_t rt,
   output mips_pkg::reg_idx_t dest,
   output mips_pkg::word_t    imm,
   output logic               use_imm,
   output logic               use_shamt,
   output logic               reg_write,
   output logic               link,
   output logic               is_bne,
   output logic               halt_req
);
   import mips_pkg::*;

   logic [5:0] opcode;
   logic [5:0] funct;
   logic       sign_ext;

   assign opcode = inst[31:26];
   assign funct  = inst[5:0];
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];

   // logic immediates are zero extended, the rest sign extended
   assign imm = sign_ext ? {{16{inst[15]}}, inst[15:0]} : {16'h0000, inst[15:0]};

   always_comb
   begin
      // defaults decode as a harmless nop
      alu_op    = ALU_ADD;
      mem_op    = MEM_NONE;
      pc_sel    = PC_SEQ;
      dest      = inst[20:16];
      sign_ext  = 1'b1;
      use_imm   = 1'b0;
      use_shamt = 1'b0;
      reg_write = 1'b0;
      link      = 1'b0;
      is_bne    = 1'b0;
      halt_req  = 1'b0;
      case (opcode)
         `MIPS_OP_SPECIAL:
         begin
            // r-type writes rd
            dest      = inst[15:11];
            reg_write = 1'b1;
            case (funct)
               `MIPS_FN_ADDU: alu_op = ALU_ADD;
               `MIPS_FN_SUBU: alu_op = ALU_SUB;
               `MIPS_FN_AND:  alu_op = ALU_AND;
               `MIPS_FN_OR:   alu_op = ALU_OR;
               `MIPS_FN_XOR:  alu_op = ALU_XOR;
               `MIPS_FN_NOR:  alu_op = ALU_NOR;
               `MIPS_FN_SLT:  alu_op = ALU_SLT;
               `MIPS_FN_SLL,
               `MIPS_FN_SRL,
               `MIPS_FN_SRA:
               begin
                  // low funct bits pick the shift kind
                  alu_op    = (funct[1:0] == 2'b00) ? ALU_SLL :
                              (funct[1:0] == 2'b10) ? ALU_SRL : ALU_SRA;
                  use_shamt = 1'b1;
               end
               `MIPS_FN_JR:
               begin
                  pc_sel    = PC_REG;
                  reg_write = 1'b0;
               end
               `MIPS_FN_SYSCALL:
               begin
                  reg_write = 1'b0;
                  halt_req  = 1'b1;
               end
               default:
               begin
                  // unknown function code stops the core too
                  reg_write = 1'b0;
                  halt_req  = 1'b1;
               end
            endcase
         end
         `MIPS_OP_ADDIU,
         `MIPS_OP_ANDI,
         `MIPS_OP_ORI,
         `MIPS_OP_XORI,
         `MIPS_OP_LUI:
         begin
            use_imm   = 1'b1;
            reg_write = 1'b1;
            // only addiu keeps the sign
            sign_ext  = (opcode == `MIPS_OP_ADDIU);
            case (opcode)
               `MIPS_OP_ANDI: alu_op = ALU_AND;
               `MIPS_OP_ORI:  alu_op = ALU_OR;
               `MIPS_OP_XORI: alu_op = ALU_XOR;
               `MIPS_OP_LUI:  alu_op = ALU_LUI;
               default:       alu_op = ALU_ADD;
            endcase
         end
         `MIPS_OP_LW,
         `MIPS_OP_LB,
         `MIPS_OP_LBU:
         begin
            // address is rs plus offset
            use_imm   = 1'b1;
            reg_write = 1'b1;
            mem_op    = (opcode == `MIPS_OP_LW) ? MEM_LW :
                        (opcode == `MIPS_OP_LB) ? MEM_LB : MEM_LBU;
         end
         `MIPS_OP_SW,
         `MIPS_OP_SB:
         begin
            use_imm = 1'b1;
            mem_op  = (opcode == `MIPS_OP_SW) ? MEM_SW : MEM_SB;
         end
         `MIPS_OP_BEQ,
         `MIPS_OP_BNE:
         begin
            // alu compares rs with rt
            pc_sel = PC_BRANCH;
            is_bne = (opcode == `MIPS_OP_BNE);
         end
         `MIPS_OP_J:
            pc_sel = PC_JUMP;
         `MIPS_OP_JAL:
         begin
            pc_sel    = PC_JUMP;
            link      = 1'b1;
            reg_write = 1'b1;
         end
         default:
            halt_req = 1'b1;
      endcase
   end

endmodule

// File: src/pc_unit.sv
// program counter with delay slot
`timescale 1ns/1ps
`include "mips_params.svh"

module pc_unit (
   input  logic              clk,
   input  logic              rst_b,
   input  mips_pkg::pc_sel_e pc_sel,
   input  logic              is_bne,
   input  logic              alu_zero,
   input  mips_pkg::word_t   imm,
   input  logic [25:0]       jump_index,
   input  mips_pkg::word_t   rs_data,
   input  logic              halt_req,
   output mips_pkg::word_t   pc,
   output mips_pkg::word_t   link_addr,
   output logic              halted
);
   import mips_pkg::*;

   // address of the delay slot instruction
   word_t next_pc;
   word_t target;
   logic  taken;
   logic  hold;

   // beq wants equal operands, bne wants them different
   assign taken     = alu_zero ^ is_bne;
   assign hold      = halted | halt_req;
   // return lands after the delay slot
   assign link_addr = pc + 32'd8;

   // target only takes effect one instruction later
   always_comb
   begin
      case (pc_sel)
         PC_BRANCH: target = taken ? pc + 32'd4 + {imm[29:0], 2'b00} : next_pc + 32'd4;
         PC_JUMP:   target = {pc[31:28], jump_index, 2'b00};
         PC_REG:    target = rs_data;
         default:   target = next_pc + 32'd4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc      <= `MIPS_TEXT_START;
         next_pc <= `MIPS_TEXT_START + 32'd4;
         halted  <= 1'b0;
      end
      else
      begin
         // both registers freeze on the halting instruction itself
         if (!hold)
         begin
            pc      <= next_pc;
            next_pc <= target;
         end
         // sticky until the next reset
         if (halt_req)
         begin
            halted <= 1'b1;
         end
      end
   end

endmodule

// File: src/mem_align.sv
// load and store byte alignment
`timescale 1ns/1ps

module mem_align (
   input  mips_pkg::mem_op_e  mem_op,
   input  logic [1:0]         byte_sel,
   input  mips_pkg::word_t    rt_data,
   input  mips_pkg::word_t    mem_data_out,
   input  logic               halted,
   output mips_pkg::byte_en_t mem_write_en,
   output mips_pkg::word_t    mem_data_in,
   output mips_pkg::word_t    load_data
);
   import mips_pkg::*;

   logic [7:0] lane;

   // big-endian lanes, offset 0 is the top byte
   always_comb
   begin
      case (byte_sel)
         2'd0:    lane = mem_data_out[31:24];
         2'd1:    lane = mem_data_out[23:16];
         2'd2:    lane = mem_data_out[15:8];
         default: lane = mem_data_out[7:0];
      endcase
   end

   always_comb
   begin
      case (mem_op)
         MEM_LB:  load_data = {{24{lane[7]}}, lane};
         MEM_LBU: load_data = {24'h000000, lane};
         default: load_data = mem_data_out;
      endcase
   end

   // sb puts the byte on every lane, the mask picks one
   assign mem_data_in = (mem_op == MEM_SB) ? {4{rt_data[7:0]}} : rt_data;

   always_comb
   begin
      mem_write_en = '0;
      // a halted core never writes memory
      if (!halted)
      begin
         case (mem_op)
            MEM_SW:  mem_write_en = 4'b1111;
            MEM_SB:  mem_write_en = 4'b1000 >> byte_sel;
            default: mem_write_en = 4'b0000;
         endcase
      end
   end

endmodule

// File: src/regfile.sv
// general purpose register file
`timescale 1ns/1ps
`include "mips_params.svh"

module regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t    wr_data,
   input  logic               wr_en,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data
);
   import mips_pkg::*;

   word_t regs [`MIPS_REG_COUNT];

   // single write port, updated at the clock edge
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < `MIPS_REG_COUNT; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr_en && (wr_idx != '0))
      begin
         regs[wr_idx] <= wr_data;
      end
   end

   // $zero is hardwired on both read ports
   assign rs_data = (rs == '0) ? '0 : regs[rs];
   assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

// File: src/mips_alu.sv
// integer alu
`timescale 1ns/1ps

module mips_alu (
   input  mips_pkg::word_t   op_a,
   input  mips_pkg::word_t   op_b,
   input  logic [4:0]        shamt,
   input  mips_pkg::alu_op_e alu_op,
   output mips_pkg::word_t   result,
   output logic              zero
);
   import mips_pkg::*;

   always_comb
   begin
      case (alu_op)
         ALU_ADD:
            result = op_a + op_b;
         ALU_SUB:
            result = op_a - op_b;
         ALU_AND:
            result = op_a & op_b;
         ALU_OR:
            result = op_a | op_b;
         ALU_XOR:
            result = op_a ^ op_b;
         ALU_NOR:
            result = ~(op_a | op_b);
         ALU_SLT:
         begin
            // two's complement compare
            result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         end
         // shifts take rt on operand a and the shamt field
         ALU_SLL:
            result = op_a << shamt;
         ALU_SRL:
            result = op_a >> shamt;
         ALU_SRA:
         begin
            // sign bit fills from the left
            result = $signed(op_a) >>> shamt;
         end
         ALU_LUI:
            result = {op_b[15:0], 16'h0000};
         default:
            result = op_a + op_b;
      endcase
   end

   // equality flag feeds the beq/bne decision
   assign zero = (op_a == op_b);

endmodule

// File: common/mips_pkg.sv
// mips core types
package mips_pkg;

   // one architectural word, data or byte address
   typedef logic [31:0] word_t;

   // byte address with its two low bits dropped
   typedef logic [29:0] word_addr_t;

   // register file index
   typedef logic [4:0] reg_idx_t;

   // store lane mask, bit 3 is the most significant byte
   typedef logic [3:0] byte_en_t;

   // alu operations
   // lui moves the low half of operand b to the top
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_e;

   // data memory access kind
   typedef enum logic [2:0] {
      MEM_NONE,
      MEM_LW,
      MEM_LB,
      MEM_LBU,
      MEM_SW,
      MEM_SB
   } mem_op_e;

   // source of the address fetched after the delay slot
   typedef enum logic [1:0] {
      PC_SEQ,
      PC_BRANCH,
      PC_JUMP,
      PC_REG
   } pc_sel_e;

endpackage

// File: common/mips_params.svh
// mips core constants
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// first fetch address after reset
`define MIPS_TEXT_START 32'h0040_0000
// jal writes its return address here
`define MIPS_LINK_REG   5'd31
`define MIPS_REG_COUNT  32

// primary opcodes
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LB      6'h20
`define MIPS_OP_LW      6'h23
`define MIPS_OP_LBU     6'h24
`define MIPS_OP_SB      6'h28
`define MIPS_OP_SW      6'h2b

// function codes under the special opcode
`define MIPS_FN_SLL     6'h00
`define MIPS_FN_SRL     6'h02
`define MIPS_FN_SRA     6'h03
`define MIPS_FN_JR      6'h08
`define MIPS_FN_SYSCALL 6'h0c
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a

`endif
